// File: hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and bus width
`define WORD_W 32

// general purpose registers R0..R15
`define NUM_REGS 16

// program and data share one memory
`define MEM_DEPTH 256

// address bits for MAR and the loader port
`define MEM_AW 8

// first fetch address after reset
`define PC_RESET 0

`endif

// File: hw/cpuPkg.sv
package cpuPkg;

    // unlisted codes fall into halt
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opShr  = 5'd7,
        opAddi = 5'd8,
        opAndi = 5'd9,
        opBr   = 5'd10,
        opIn   = 5'd11,
        opOut  = 5'd12,
        opHalt = 5'd13
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShr,
        aluPassB
    } aluOpE;

    typedef enum logic [3:0] {
        srcReg,
        srcPc,
        srcMdr,
        srcZLow,
        srcInPort,
        srcCConst,
        srcNone
    } busSrcE;

    // one strobe set per step, driven by the control unit
    typedef struct packed {
        logic  gra;
        logic  grb;
        logic  grc;
        logic  rIn;
        logic  rOut;
        logic  baOut;
        logic  pcOut;
        logic  mdrOut;
        logic  zOut;
        logic  inPortOut;
        logic  cOut;
        logic  pcIn;
        logic  irIn;
        logic  marIn;
        logic  mdrIn;
        logic  yIn;
        logic  zIn;
        logic  outPortIn;
        logic  conIn;
        logic  incPc;
        logic  memRead;
        logic  memWrite;
        aluOpE aluOp;
    } ctrlS;

    // rc sits in the top of the immediate field
    typedef struct packed {
        logic [3:0]  rc;
        logic [14:0] spare;
    } rcFieldS;

    // low 19 bits seen either as rc or as the constant
    typedef union packed {
        rcFieldS     f;
        logic [18:0] imm;
    } tailU;

    typedef struct packed {
        opcodeE     opcode;
        logic [3:0] ra;
        logic [3:0] rb;
        tailU       tail;
    } instrS;

endpackage

// File: hw/regFile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module regFile (
    input  logic                 clock,
    input  logic                 rst,
    input  logic [`NUM_REGS-1:0] wrEn,
    input  logic [`NUM_REGS-1:0] rdSel,
    input  logic                 baOut,
    input  logic [`WORD_W-1:0]   busIn,
    output logic [`WORD_W-1:0]   rdData
);

    logic [`WORD_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if (wrEn[i]) begin
                    regs[i] <= busIn;
                end
            end
        end
    end

    always_comb begin
        rdData = '0;
        for (int i = 1; i < `NUM_REGS; i++) begin
            if (rdSel[i]) begin
                rdData = regs[i];
            end
        end
        // R0 used as a base gives address zero
        if (rdSel[0] && !baOut) begin
            rdData = regs[0];
        end
    end

    // selects come from the IR decoder, one register at a time
    assert property (@(posedge clock) disable iff (rst) $onehot0(wrEn))
        else $error("regFile: wrEn not one-hot");
    assert property (@(posedge clock) disable iff (rst) $onehot0(rdSel))
        else $error("regFile: rdSel not one-hot");

endmodule

// File: hw/busMux.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module busMux import cpuPkg::*; (
    input  logic [`WORD_W-1:0] regData,
    input  logic [`WORD_W-1:0] pcData,
    input  logic [`WORD_W-1:0] mdrData,
    input  logic [`WORD_W-1:0] zData,
    input  logic [`WORD_W-1:0] inPortData,
    input  logic [`WORD_W-1:0] cData,
    input  ctrlS               ctrl,
    output logic [`WORD_W-1:0] bus
);

    busSrcE     src;
    logic [5:0] outReq;

    // register read covers both Rout and BAout
    assign outReq = {ctrl.rOut | ctrl.baOut, ctrl.pcOut, ctrl.mdrOut,
                     ctrl.zOut, ctrl.inPortOut, ctrl.cOut};

    // fixed priority, registers first
    always_comb begin
        if (outReq[5]) src = srcReg;
        else if (outReq[4]) src = srcPc;
        else if (outReq[3]) src = srcMdr;
        else if (outReq[2]) src = srcZLow;
        else if (outReq[1]) src = srcInPort;
        else if (outReq[0]) src = srcCConst;
        else src = srcNone;
    end

    always_comb begin
        case (src)
            srcReg:    bus = regData;
            srcPc:     bus = pcData;
            srcMdr:    bus = mdrData;
            srcZLow:   bus = zData;
            srcInPort: bus = inPortData;
            srcCConst: bus = cData;
            default:   bus = '0;
        endcase
    end

    // control unit drives a single source per step
    always_comb begin
        assert ($onehot0(outReq))
            else $error("busMux: several bus sources at once");
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu import cpuPkg::*; (
    input  logic [`WORD_W-1:0] a,
    input  logic [`WORD_W-1:0] b,
    input  aluOpE              op,
    output logic [`WORD_W-1:0] result
);

    localparam int ShW = $clog2(`WORD_W);

    // a is Y, b is the bus
    always_comb begin
        case (op)
            // add and sub simply wrap
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            // logical shift, amount from low bits of b
            aluShr:  result = a >> b[ShW-1:0];
            aluPassB: result = b;
            default: result = b;
        endcase
    end

endmodule

// File: hw/irDecode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module irDecode import cpuPkg::*; (
    input  instrS                instr,
    input  ctrlS                 ctrl,
    output logic [`NUM_REGS-1:0] regSel,
    output logic [`WORD_W-1:0]   cSignExt
);

    localparam int ImmW = 19;
    localparam int SelW = $clog2(`NUM_REGS);

    logic [SelW-1:0] regIdx;

    // register field picked by Gra/Grb/Grc
    always_comb begin
        regIdx = instr.ra;
        if (ctrl.grb) begin
            regIdx = instr.rb;
        end else if (ctrl.grc) begin
            regIdx = instr.tail.f.rc;
        end
    end

    // one-hot only when some field is requested
    assign regSel = (ctrl.gra || ctrl.grb || ctrl.grc) ?
                    (`NUM_REGS'(1) << regIdx) : '0;

    // 19-bit constant widened with its sign
    assign cSignExt = {{(`WORD_W - ImmW){instr.tail.imm[ImmW-1]}}, instr.tail.imm};

endmodule

// File: hw/memory.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module memory (
    input  logic               clock,
    input  logic [`MEM_AW-1:0] addr,
    input  logic [`WORD_W-1:0] wrData,
    input  logic               rdEn,
    input  logic               wrEn,
    input  logic               progWe,
    input  logic [`MEM_AW-1:0] progAddr,
    input  logic [`WORD_W-1:0] progData,
    output logic [`WORD_W-1:0] rdData
);

    logic [`WORD_W-1:0] mem [`MEM_DEPTH];

    always_ff @(posedge clock) begin
        // loader wins over the CPU port
        if (progWe) begin
            mem[progAddr] <= progData;
        end else if (wrEn) begin
            mem[addr] <= wrData;
        end
        // registered read, one cycle latency
        if (rdEn) begin
            rdData <= mem[addr];
        end
    end

    // loading only happens before the run starts
    assert property (@(posedge clock) !(progWe && wrEn))
        else $error("memory: loader and CPU write together");

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module controlUnit import cpuPkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               run,
    input  instrS              instr,
    input  logic [`WORD_W-1:0] bus,
    input  logic               inReq,
    output ctrlS               ctrl,
    output logic               inAck,
    output logic               inLatch,
    output logic               outValid,
    output logic               done
);

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stHalt
    } cuStateE;

    cuStateE    state;
    logic [2:0] step;
    logic       conQ;
    logic       condMet;
    logic       stall;
    logic       lastStep;
    logic       haltNow;

    // branch condition from IR[20:19] against Ra on the bus
    always_comb begin
        case (instr.rb[1:0])
            2'd0:    condMet = (bus == '0);
            2'd1:    condMet = (bus != '0);
            2'd2:    condMet = !bus[`WORD_W-1];
            default: condMet = bus[`WORD_W-1];
        endcase
    end

    always_comb begin
        ctrl = '0;
        inLatch = 1'b0;
        stall = 1'b0;
        lastStep = 1'b0;
        haltNow = 1'b0;
        // alu function follows the opcode and defaults to add for address math
        case (instr.opcode)
            opSub:        ctrl.aluOp = aluSub;
            opAnd, opAndi: ctrl.aluOp = aluAnd;
            opOr:         ctrl.aluOp = aluOr;
            opShr:        ctrl.aluOp = aluShr;
            default:      ctrl.aluOp = aluAdd;
        endcase
        if (state == stRun) begin
            case (step)
                3'd0: begin
                    ctrl.pcOut = 1'b1;
                    ctrl.marIn = 1'b1;
                    ctrl.incPc = 1'b1;
                end
                3'd1: begin
                    // Y keeps PC+1 as the branch base
                    ctrl.pcOut = 1'b1;
                    ctrl.yIn = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.mdrIn = 1'b1;
                end
                3'd2: begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.irIn = 1'b1;
                end
                3'd3: begin
                    case (instr.opcode)
                        opAdd, opSub, opAnd, opOr, opShr, opAddi, opAndi: begin
                            ctrl.grb = 1'b1;
                            ctrl.rOut = 1'b1;
                            ctrl.yIn = 1'b1;
                        end
                        opLd, opLdi: begin
                            ctrl.grb = 1'b1;
                            ctrl.baOut = 1'b1;
                            ctrl.yIn = 1'b1;
                        end
                        opSt: begin
                            ctrl.gra = 1'b1;
                            ctrl.rOut = 1'b1;
                            ctrl.mdrIn = 1'b1;
                        end
                        opBr: begin
                            ctrl.gra = 1'b1;
                            ctrl.rOut = 1'b1;
                            ctrl.conIn = 1'b1;
                        end
                        opIn: begin
                            // wait for the device request
                            inLatch = inReq;
                            stall = !inReq;
                        end
                        opOut: begin
                            ctrl.gra = 1'b1;
                            ctrl.rOut = 1'b1;
                            ctrl.outPortIn = 1'b1;
                            lastStep = 1'b1;
                        end
                        default: haltNow = 1'b1;
                    endcase
                end
                3'd4: begin
                    case (instr.opcode)
                        opAdd, opSub, opAnd, opOr, opShr: begin
                            ctrl.grc = 1'b1;
                            ctrl.rOut = 1'b1;
                            ctrl.zIn = 1'b1;
                        end
                        opAddi, opAndi, opLd, opLdi, opBr: begin
                            ctrl.cOut = 1'b1;
                            ctrl.zIn = 1'b1;
                        end
                        opSt: begin
                            ctrl.grb = 1'b1;
                            ctrl.baOut = 1'b1;
                            ctrl.yIn = 1'b1;
                        end
                        opIn: begin
                            // hold ack until the request drops
                            stall = inReq;
                            ctrl.inPortOut = !inReq;
                            ctrl.gra = !inReq;
                            ctrl.rIn = !inReq;
                            lastStep = !inReq;
                        end
                        default: ;
                    endcase
                end
                3'd5: begin
                    case (instr.opcode)
                        opLd: begin
                            ctrl.zOut = 1'b1;
                            ctrl.marIn = 1'b1;
                        end
                        opSt: begin
                            ctrl.cOut = 1'b1;
                            ctrl.zIn = 1'b1;
                        end
                        opBr: begin
                            // target only taken when the flag is set
                            ctrl.zOut = 1'b1;
                            ctrl.pcIn = conQ;
                            lastStep = 1'b1;
                        end
                        default: begin
                            ctrl.zOut = 1'b1;
                            ctrl.gra = 1'b1;
                            ctrl.rIn = 1'b1;
                            lastStep = 1'b1;
                        end
                    endcase
                end
                3'd6: begin
                    if (instr.opcode == opSt) begin
                        // MAR load and write share the cycle
                        ctrl.zOut = 1'b1;
                        ctrl.marIn = 1'b1;
                        ctrl.memWrite = 1'b1;
                        lastStep = 1'b1;
                    end else begin
                        ctrl.memRead = 1'b1;
                        ctrl.mdrIn = 1'b1;
                    end
                end
                default: begin
                    // only ld gets this far
                    ctrl.mdrOut = 1'b1;
                    ctrl.gra = 1'b1;
                    ctrl.rIn = 1'b1;
                    lastStep = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= stIdle;
            step <= '0;
            conQ <= 1'b0;
            inAck <= 1'b0;
            outValid <= 1'b0;
            done <= 1'b0;
        end else begin
            outValid <= ctrl.outPortIn;
            if (ctrl.conIn) begin
                conQ <= condMet;
            end
            if (inLatch) begin
                inAck <= 1'b1;
            end else if (ctrl.inPortOut) begin
                inAck <= 1'b0;
            end
            if (state == stIdle && run) begin
                state <= stRun;
            end else if (haltNow) begin
                state <= stHalt;
                done <= 1'b1;
            end
            if (lastStep) begin
                step <= '0;
            end else if (state == stRun && !stall) begin
                step <= step + 1'b1;
            end
        end
    end

    // ack only answers a live request
    assert property (@(posedge clock) disable iff (rst) $rose(inAck) |-> $past(inReq))
        else $error("controlUnit: inAck rose without inReq");
    // device keeps its request up until the ack arrives
    assert property (@(posedge clock) disable iff (rst) inReq && !inAck |=> inReq || inAck)
        else $error("controlUnit: inReq dropped before inAck");

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath import cpuPkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               run,
    input  logic               inReq,
    input  logic [`WORD_W-1:0] inData,
    input  logic               progWe,
    input  logic [`MEM_AW-1:0] progAddr,
    input  logic [`WORD_W-1:0] progData,
    output logic               inAck,
    output logic [`WORD_W-1:0] outData,
    output logic               outValid,
    output logic               done
);

    ctrlS                 ctrl;
    instrS                ir;
    logic                 inLatch;
    logic [`WORD_W-1:0]   bus;
    logic [`WORD_W-1:0]   pc;
    logic [`WORD_W-1:0]   mdr;
    logic [`WORD_W-1:0]   y;
    logic [`WORD_W-1:0]   z;
    logic [`WORD_W-1:0]   inReg;
    logic [`WORD_W-1:0]   aluResult;
    logic [`WORD_W-1:0]   regRdData;
    logic [`WORD_W-1:0]   cSignExt;
    logic [`WORD_W-1:0]   memRdData;
    logic [`MEM_AW-1:0]   mar;
    logic [`MEM_AW-1:0]   memAddr;
    logic [`NUM_REGS-1:0] regSel;
    logic [`NUM_REGS-1:0] regWrEn;
    logic [`NUM_REGS-1:0] regRdSel;

    // decoder output gated by the read or write strobe
    assign regWrEn = ctrl.rIn ? regSel : '0;
    assign regRdSel = (ctrl.rOut || ctrl.baOut) ? regSel : '0;

    // MAR bypass so memory samples the address as MAR loads
    assign memAddr = ctrl.marIn ? bus[`MEM_AW-1:0] : mar;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= `WORD_W'(`PC_RESET);
        end else if (ctrl.pcIn) begin
            pc <= bus;
        end else if (ctrl.incPc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.irIn) ir <= instrS'(bus);
        if (ctrl.marIn) mar <= bus[`MEM_AW-1:0];
        // MDR fills from memory on a read, else from the bus
        if (ctrl.mdrIn) mdr <= ctrl.memRead ? memRdData : bus;
        if (ctrl.yIn) y <= bus;
        if (ctrl.zIn) z <= aluResult;
        if (inLatch) inReg <= inData;
        if (ctrl.outPortIn) outData <= bus;
    end

    regFile regFile_i (
        .clock (clock),
        .rst   (rst),
        .wrEn  (regWrEn),
        .rdSel (regRdSel),
        .baOut (ctrl.baOut),
        .busIn (bus),
        .rdData(regRdData)
    );

    busMux busMux_i (
        .regData   (regRdData),
        .pcData    (pc),
        .mdrData   (mdr),
        .zData     (z),
        .inPortData(inReg),
        .cData     (cSignExt),
        .ctrl      (ctrl),
        .bus       (bus)
    );

    alu alu_i (
        .a     (y),
        .b     (bus),
        .op    (ctrl.aluOp),
        .result(aluResult)
    );

    irDecode irDecode_i (
        .instr   (ir),
        .ctrl    (ctrl),
        .regSel  (regSel),
        .cSignExt(cSignExt)
    );

    // read issued when MAR loads, loader locked out once running
    memory memory_i (
        .clock   (clock),
        .addr    (memAddr),
        .wrData  (mdr),
        .rdEn    (ctrl.marIn),
        .wrEn    (ctrl.memWrite),
        .progWe  (progWe && !run),
        .progAddr(progAddr),
        .progData(progData),
        .rdData  (memRdData)
    );

    controlUnit controlUnit_i (
        .clock   (clock),
        .rst     (rst),
        .run     (run),
        .instr   (ir),
        .bus     (bus),
        .inReq   (inReq),
        .ctrl    (ctrl),
        .inAck   (inAck),
        .inLatch (inLatch),
        .outValid(outValid),
        .done    (done)
    );

endmodule

// File: dv/datapathTb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapathTb import cpuPkg::*; #(
    parameter int Seed = 66
) ();

    localparam int ProgLen = 48;
    localparam int DriveDelay = 1;
    localparam int DataBase = 128;
    // per instruction: fetch and longest execute, plus handshake slack
    localparam int MaxCycles = ProgLen * (8 + 10) + 200;

    logic               clock;
    logic               rst;
    logic               run;
    logic               inReq;
    logic [`WORD_W-1:0] inData;
    logic               progWe;
    logic [`MEM_AW-1:0] progAddr;
    logic [`WORD_W-1:0] progData;
    logic               inAck;
    logic [`WORD_W-1:0] outData;
    logic               outValid;
    logic               done;

    int                 seed;
    int                 cycleCount;
    int                 outIdx;
    logic               doneSeen;
    logic               prevAck;
    logic               prevReq;
    logic [`WORD_W-1:0] image [`MEM_DEPTH];
    logic [`WORD_W-1:0] inVals [ProgLen];
    logic [`WORD_W-1:0] expOuts [$];

    datapath dut_i (
        .clock   (clock),
        .rst     (rst),
        .run     (run),
        .inReq   (inReq),
        .inData  (inData),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .inAck   (inAck),
        .outData (outData),
        .outValid(outValid),
        .done    (done)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic failRun(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkWord(input string name, input logic [`WORD_W-1:0] got,
                             input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            failRun("wrong word on a DUT output");
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            failRun("wrong bit on a DUT output");
        end
    endtask

    // inputs change a little after the rising edge
    task automatic nextDriveSlot();
        @(posedge clock);
        #(DriveDelay);
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [`WORD_W-1:0] encode(input opcodeE op, input int ra, input int rb,
                                                  input logic [18:0] tail);
        return {op, 4'(ra), 4'(rb), tail};
    endfunction

    task automatic buildProgram();
        int          kind;
        int          ra;
        int          off;
        int          lastDest;
        int          brCount;
        int          stAddrs [$];
        opcodeE      op;
        logic [18:0] imm;
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            // every address bit shows up in the fill word
            image[a] = {8'hc3, 8'(a), ~8'(a), 8'(a) ^ 8'h5a};
        end
        for (int k = 0; k < ProgLen; k++) begin
            inVals[k] = $random(seed);
        end
        // nonzero R0 so a zero base cannot hide behind it
        image[0] = encode(opLdi, 0, 0, 19'(randBelow(4096) + 1));
        lastDest = 0;
        brCount = 0;
        for (int i = 1; i < ProgLen - 1; i++) begin
            // first pass walks every opcode, then extra branches
            if (i <= 13) kind = i - 1;
            else if (i <= 16) kind = int'(opBr);
            else kind = randBelow(16);
            if (kind == 13 || kind == 14) kind = int'(opOut);
            if (kind == 15) kind = int'(opBr);
            op = opcodeE'(kind);
            ra = randBelow(16);
            imm = 19'($random(seed));
            case (op)
                opLd: begin
                    // reload a stored word half of the time
                    if (stAddrs.size() > 0 && randBelow(2) == 1) begin
                        off = stAddrs[randBelow(stAddrs.size())];
                    end else begin
                        off = DataBase + randBelow(128);
                    end
                    image[i] = encode(op, ra, 0, 19'(off));
                    lastDest = ra;
                end
                opSt: begin
                    off = DataBase + randBelow(128);
                    stAddrs.push_back(off);
                    image[i] = encode(op, ra, 0, 19'(off));
                end
                opLdi, opAddi, opAndi: begin
                    image[i] = encode(op, ra, randBelow(16), imm);
                    lastDest = ra;
                end
                opBr: begin
                    // forward skip of 0..3, never past halt
                    off = randBelow((ProgLen - 2 - i < 3 ? ProgLen - 2 - i : 3) + 1);
                    image[i] = encode(op, ra, randBelow(4) * 4 + brCount % 4, 19'(off));
                    brCount++;
                end
                opIn: begin
                    image[i] = encode(op, ra, 0, '0);
                    lastDest = ra;
                end
                opOut: begin
                    // mostly show the newest result
                    if (randBelow(2) == 1) ra = lastDest;
                    image[i] = encode(op, ra, 0, '0);
                end
                default: begin
                    image[i] = encode(op, ra, randBelow(16), {4'(randBelow(16)), imm[14:0]});
                    lastDest = ra;
                end
            endcase
        end
        image[ProgLen - 1] = encode(opHalt, 0, 0, '0);
    endtask

    // instruction-set model, collects the expected out values
    task automatic runModel();
        logic [`WORD_W-1:0] regs [`NUM_REGS];
        logic [`WORD_W-1:0] mem [`MEM_DEPTH];
        logic [`WORD_W-1:0] word;
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] immExt;
        logic [`WORD_W-1:0] base;
        logic [`MEM_AW-1:0] addr;
        logic [3:0]         ra;
        logic [3:0]         rb;
        logic [3:0]         rc;
        logic               taken;
        logic               running;
        opcodeE             op;
        int                 inIdx;
        mem = image;
        for (int r = 0; r < `NUM_REGS; r++) begin
            regs[r] = '0;
        end
        pc = `WORD_W'(`PC_RESET);
        inIdx = 0;
        running = 1'b1;
        while (running) begin
            word = mem[pc[`MEM_AW-1:0]];
            pc = pc + 1;
            op = opcodeE'(word[31:27]);
            ra = word[26:23];
            rb = word[22:19];
            rc = word[18:15];
            immExt = {{(`WORD_W - 19){word[18]}}, word[18:0]};
            // R0 counts as zero only as a base
            base = (rb == 4'd0) ? '0 : regs[rb];
            addr = `MEM_AW'(base + immExt);
            case (op)
                opLd:   regs[ra] = mem[addr];
                opLdi:  regs[ra] = base + immExt;
                opSt:   mem[addr] = regs[ra];
                opAdd:  regs[ra] = regs[rb] + regs[rc];
                opSub:  regs[ra] = regs[rb] - regs[rc];
                opAnd:  regs[ra] = regs[rb] & regs[rc];
                opOr:   regs[ra] = regs[rb] | regs[rc];
                opShr:  regs[ra] = regs[rb] >> regs[rc][4:0];
                opAddi: regs[ra] = regs[rb] + immExt;
                opAndi: regs[ra] = regs[rb] & immExt;
                opBr: begin
                    case (rb[1:0])
                        2'd0:    taken = (regs[ra] == '0);
                        2'd1:    taken = (regs[ra] != '0);
                        2'd2:    taken = !regs[ra][`WORD_W-1];
                        default: taken = regs[ra][`WORD_W-1];
                    endcase
                    if (taken) pc = pc + immExt;
                end
                opIn: begin
                    regs[ra] = inVals[inIdx];
                    inIdx++;
                end
                opOut:  expOuts.push_back(regs[ra]);
                default: running = 1'b0;
            endcase
        end
    endtask

    // device side of the four-phase input port
    initial begin
        int delay;
        wait (run);
        for (int k = 0; k < ProgLen; k++) begin
            delay = randBelow(6);
            repeat (delay) nextDriveSlot();
            inData = inVals[k];
            inReq = 1'b1;
            do nextDriveSlot(); while (!inAck);
            inReq = 1'b0;
            do nextDriveSlot(); while (inAck);
        end
    end

    always @(negedge clock) begin
        if (!rst) begin
            // ack edges judged against req at that same clock edge
            if (inAck && !prevAck) checkBit("inReq at inAck rise", prevReq, 1'b1);
            if (!inAck && prevAck) checkBit("inReq at inAck fall", prevReq, 1'b0);
            if (outValid) begin
                if (outIdx >= expOuts.size()) begin
                    $display("out pulse %0d at %0t ns has no expected value", outIdx, $time);
                    failRun("more out pulses than the model predicts");
                end else begin
                    checkWord("outData", outData, expOuts[outIdx]);
                    outIdx++;
                end
            end
            // done is sticky until reset
            if (doneSeen) checkBit("done", done, 1'b1);
            doneSeen = doneSeen | done;
        end
        prevAck = inAck;
        prevReq = inReq;
    end

    always @(negedge clock) begin
        if (run && !done) begin
            cycleCount++;
            if (cycleCount > MaxCycles) begin
                $display("timeout: program never finished after %0d cycles", MaxCycles);
                failRun("program never reached halt");
            end
        end
    end

    initial begin
        seed = Seed;
        rst = 1'b1;
        run = 1'b0;
        inReq = 1'b0;
        inData = '0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        cycleCount = 0;
        outIdx = 0;
        doneSeen = 1'b0;
        prevAck = 1'b0;
        prevReq = 1'b0;
        buildProgram();
        runModel();
        repeat (5) nextDriveSlot();
        rst = 1'b0;
        @(negedge clock);
        checkBit("done", done, 1'b0);
        checkBit("inAck", inAck, 1'b0);
        checkBit("outValid", outValid, 1'b0);
        // whole memory image through the loader
        nextDriveSlot();
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            progWe = 1'b1;
            progAddr = `MEM_AW'(a);
            progData = image[a];
            nextDriveSlot();
        end
        progWe = 1'b0;
        nextDriveSlot();
        run = 1'b1;
        do @(negedge clock); while (!done);
        // let a stray pulse show up if there is one
        repeat (8) @(negedge clock);
        @(posedge clock);
        if (outIdx == expOuts.size()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("mismatch at %0t ns: out pulse count got %0d expected %0d",
                     $time, outIdx, expOuts.size());
            failRun("wrong number of out pulses");
        end
    end

endmodule

// File: files.f
+incdir+hw
hw/cpuPkg.sv
hw/regFile.sv
hw/busMux.sv
hw/alu.sv
hw/irDecode.sv
hw/memory.sv
hw/controlUnit.sv
hw/datapath.sv
dv/datapathTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= datapathTb
SEED ?= 66
OBJ_DIR ?= obj_dir
FILE_LIST ?= files.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build and run, a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) -f $(FILE_LIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
